/* logic/ooo_commit_pkg.sv */
`default_nettype none

package ooo_commit_pkg;

  // Widths that carry a meaning.
  typedef logic [31:0] word_t;     // Data word or address.
  typedef logic [4:0]  reg_idx_t;  // Architectural register number.
  typedef logic [2:0]  cb_idx_t;   // Completion buffer slot.
  typedef logic [3:0]  bht_idx_t;  // History table slot, pc[5:2].
  typedef logic [1:0]  bht_cnt_t;  // Saturating branch counter.
  typedef logic [3:0]  cause_t;    // Trap cause code.

  // Sizes.
  localparam int CB_DEPTH    = 8;   // Completion buffer entries.
  localparam int BHT_ENTRIES = 16;  // History table entries.

  // Trap causes, RISC-V numbering.
  localparam cause_t CAUSE_MAL_INSN     = 4'd0;  // Misaligned instruction address.
  localparam cause_t CAUSE_ILLEGAL_INSN = 4'd2;  // Illegal instruction.

  // Counter values used by the history table.
  // Weak taken (2) is not named, bit 1 alone marks a taken prediction.
  localparam bht_cnt_t BHT_STRONG_NT = 2'd0;  // Floor of the counter.
  localparam bht_cnt_t BHT_WEAK_NT   = 2'd1;  // Value after reset.
  localparam bht_cnt_t BHT_STRONG_T  = 2'd3;  // Ceiling of the counter.

  // Commit control FSM.
  typedef enum logic [1:0] {
    RUN,                // Retire in order.
    TRAP_WAIT_ACK,      // trap_req high, waiting for the privilege unit.
    TRAP_WAIT_RELEASE   // Ack seen, waiting for it to drop.
  } commit_state_t;

endpackage

`default_nettype wire

/* logic/ooo_commit_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_stage import ooo_commit_pkg::*; (
  // ALU writeback, also resolves branches.
  input  logic    alu_valid,
  input  cb_idx_t alu_index,
  input  word_t   alu_pc,
  input  word_t   alu_data,
  input  word_t   alu_target,
  input  logic    alu_illegal,
  input  logic    alu_branch,
  input  logic    alu_prediction,
  input  logic    alu_taken,
  // Multiplier writeback.
  input  logic    mul_valid,
  input  cb_idx_t mul_index,
  input  word_t   mul_data,
  // Completion buffer, ALU port.
  output logic    wb_a_valid,
  output cb_idx_t wb_a_index,
  output word_t   wb_a_data,
  output logic    wb_a_exception,
  output cause_t  wb_a_cause,
  output logic    wb_a_nowrite,
  output logic    wb_a_redirect,
  // Completion buffer, multiplier port.
  output logic    wb_m_valid,
  output cb_idx_t wb_m_index,
  output word_t   wb_m_data,
  // Branch history update.
  output logic    upd_valid,
  output word_t   upd_pc,
  output logic    upd_taken
);

  logic  mispredict;
  logic  mal_target;
  logic  exception;
  word_t next_pc;
  word_t trap_value;

  assign mispredict = alu_branch & (alu_prediction ^ alu_taken);
  assign mal_target = alu_branch & alu_taken & (alu_target[1:0] != 2'b00);
  assign exception  = alu_illegal | mal_target;

  assign next_pc    = alu_taken ? alu_target : alu_pc + 32'd4;  // Resolved fetch address.
  assign trap_value = alu_illegal ? '0 : alu_target;           // Bad target for mtval.

  // One word per entry, its meaning set by the flags beside it.
  always_comb begin
    if (exception) begin
      wb_a_data = trap_value;
    end else if (mispredict) begin
      wb_a_data = next_pc;
    end else begin
      wb_a_data = alu_data;
    end
  end

  assign wb_a_valid     = alu_valid;
  assign wb_a_index     = alu_index;
  assign wb_a_exception = exception;
  assign wb_a_cause     = alu_illegal ? CAUSE_ILLEGAL_INSN : CAUSE_MAL_INSN;
  assign wb_a_nowrite   = alu_branch;                  // Branches have no rd.
  assign wb_a_redirect  = mispredict & ~exception;     // A trap wins over a redirect.

  // Multiplier results never fault.
  assign wb_m_valid = mul_valid;
  assign wb_m_index = mul_index;
  assign wb_m_data  = mul_data;

  // Train the predictor at resolution, not at retirement.
  assign upd_valid = alu_valid & alu_branch;
  assign upd_pc    = alu_pc;
  assign upd_taken = alu_taken;

endmodule

`default_nettype wire

/* logic/completion_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module completion_buffer import ooo_commit_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  // Allocation from dispatch.
  input  logic     alloc_valid,
  input  word_t    alloc_pc,
  input  reg_idx_t alloc_rd,
  output logic     alloc_ready,
  output cb_idx_t  alloc_index,
  // ALU writeback port.
  input  logic     wb_a_valid,
  input  cb_idx_t  wb_a_index,
  input  word_t    wb_a_data,
  input  logic     wb_a_exception,
  input  cause_t   wb_a_cause,
  input  logic     wb_a_nowrite,
  input  logic     wb_a_redirect,
  // Multiplier writeback port.
  input  logic     wb_m_valid,
  input  cb_idx_t  wb_m_index,
  input  word_t    wb_m_data,
  // Commit control.
  input  logic     retire_en,
  input  logic     flush,
  output logic     head_ready,
  output logic     head_exception,
  output cause_t   head_cause,
  output word_t    head_pc,
  output word_t    head_value,
  // Retirement.
  output logic     retire_valid,
  output reg_idx_t retire_rd,
  output word_t    retire_data,
  output logic     retire_wen,
  output logic     redirect_valid,
  output word_t    redirect_pc
);

  // Entry payload.
  word_t    pc_q    [CB_DEPTH];
  reg_idx_t rd_q    [CB_DEPTH];
  word_t    data_q  [CB_DEPTH];
  cause_t   cause_q [CB_DEPTH];

  // Entry status.
  logic [CB_DEPTH-1:0] valid_q;     // Allocated and not yet retired.
  logic [CB_DEPTH-1:0] done_q;      // Written back.
  logic [CB_DEPTH-1:0] exc_q;
  logic [CB_DEPTH-1:0] nowrite_q;
  logic [CB_DEPTH-1:0] redirect_q;

  cb_idx_t    head;
  cb_idx_t    tail;
  logic [3:0] count;  // Holds 0 to CB_DEPTH.
  logic       alloc_fire;

  // A redirecting retirement wipes the buffer, so nothing may enter that cycle.
  assign alloc_ready = (count != 4'(CB_DEPTH)) & ~flush & ~redirect_valid;
  assign alloc_index = tail;
  assign alloc_fire  = alloc_valid & alloc_ready;

  assign head_ready     = valid_q[head] & done_q[head];
  assign head_exception = exc_q[head];
  assign head_cause     = cause_q[head];
  assign head_pc        = pc_q[head];
  assign head_value     = data_q[head];

  assign retire_valid   = retire_en & head_ready;
  assign retire_rd      = rd_q[head];
  assign retire_data    = data_q[head];
  assign retire_wen     = retire_valid & ~nowrite_q[head];
  assign redirect_valid = retire_valid & redirect_q[head];
  assign redirect_pc    = data_q[head];  // Resolved next pc.

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      valid_q    <= '0;
      done_q     <= '0;
      exc_q      <= '0;
      nowrite_q  <= '0;
      redirect_q <= '0;
    end else begin
      if (alloc_fire) begin
        valid_q[tail] <= 1'b1;
        done_q[tail]  <= 1'b0;  // Clears any stale result.
        tail          <= tail + 3'd1;
      end
      if (wb_a_valid) begin
        done_q[wb_a_index]     <= 1'b1;
        exc_q[wb_a_index]      <= wb_a_exception;
        nowrite_q[wb_a_index]  <= wb_a_nowrite;
        redirect_q[wb_a_index] <= wb_a_redirect;
      end
      if (wb_m_valid) begin
        done_q[wb_m_index]     <= 1'b1;
        exc_q[wb_m_index]      <= 1'b0;
        nowrite_q[wb_m_index]  <= 1'b0;
        redirect_q[wb_m_index] <= 1'b0;
      end
      if (retire_valid) begin
        valid_q[head] <= 1'b0;
        head          <= head + 3'd1;
      end
      count <= count + {3'b000, alloc_fire} - {3'b000, retire_valid};

      // Emptying overrides the bookkeeping above.
      if (flush) begin
        valid_q <= '0;
        tail    <= head;
        count   <= '0;
      end else if (redirect_valid) begin
        valid_q <= '0;
        tail    <= head + 3'd1;  // Same slot the head moves to.
        count   <= '0;
      end
    end
  end

  // Payload is only read once its status bits say so.
  always_ff @(posedge CLK) begin
    if (alloc_fire) begin
      pc_q[tail] <= alloc_pc;
      rd_q[tail] <= alloc_rd;
    end
    if (wb_a_valid) begin
      data_q[wb_a_index]  <= wb_a_data;
      cause_q[wb_a_index] <= wb_a_cause;
    end
    if (wb_m_valid) begin
      data_q[wb_m_index] <= wb_m_data;
    end
  end

endmodule

`default_nettype wire

/* logic/commit_control.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_control import ooo_commit_pkg::*; (
  input  logic   CLK,
  input  logic   nRST,
  // Completion buffer head.
  input  logic   head_ready,
  input  logic   head_exception,
  input  cause_t head_cause,
  input  word_t  head_pc,
  input  word_t  head_value,
  output logic   retire_en,
  output logic   flush,
  // Privilege unit, four-phase handshake.
  input  logic   trap_ack,
  output logic   trap_req,
  output word_t  trap_epc,
  output word_t  trap_value,
  output cause_t trap_cause
);

  commit_state_t state;
  commit_state_t state_next;
  logic          trap_start;

  assign trap_start = (state == RUN) & head_ready & head_exception;

  // Only clean results leave the buffer.
  assign retire_en = (state == RUN) & head_ready & ~head_exception;
  assign trap_req  = (state == TRAP_WAIT_ACK);
  assign flush     = (state == TRAP_WAIT_ACK) & trap_ack;  // One cycle, req drops with it.

  always_comb begin
    state_next = state;
    case (state)
      RUN: begin
        if (trap_start) begin
          state_next = TRAP_WAIT_ACK;
        end
      end
      TRAP_WAIT_ACK: begin
        if (trap_ack) begin
          state_next = TRAP_WAIT_RELEASE;
        end
      end
      TRAP_WAIT_RELEASE: begin
        if (!trap_ack) begin
          state_next = RUN;  // Handshake closed.
        end
      end
      default: state_next = RUN;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= RUN;
    end else begin
      state <= state_next;
    end
  end

  // Held stable for as long as trap_req is high.
  always_ff @(posedge CLK) begin
    if (trap_start) begin
      trap_epc   <= head_pc;
      trap_value <= head_value;
      trap_cause <= head_cause;
    end
  end

endmodule

`default_nettype wire

/* logic/branch_history_table.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_history_table import ooo_commit_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  // Resolution from the commit stage.
  input  logic  upd_valid,
  input  word_t upd_pc,
  input  logic  upd_taken,
  // Lookup from fetch.
  input  word_t pred_pc,
  output logic  pred_taken
);

  bht_cnt_t cnt_q [BHT_ENTRIES];
  bht_idx_t upd_idx;
  bht_idx_t pred_idx;

  assign upd_idx  = upd_pc[5:2];   // Word aligned, low bits dropped.
  assign pred_idx = pred_pc[5:2];

  assign pred_taken = cnt_q[pred_idx][1];  // Upper half of the range.

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        cnt_q[i] <= BHT_WEAK_NT;
      end
    end else if (upd_valid) begin
      if (upd_taken) begin
        if (cnt_q[upd_idx] != BHT_STRONG_T) begin
          cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
        end
      end else begin
        if (cnt_q[upd_idx] != BHT_STRONG_NT) begin
          cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ooo_commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_commit_top import ooo_commit_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  // Dispatch allocation.
  input  logic     alloc_valid,
  input  word_t    alloc_pc,
  input  reg_idx_t alloc_rd,
  output logic     alloc_ready,
  output cb_idx_t  alloc_index,
  // ALU writeback.
  input  logic     alu_valid,
  input  cb_idx_t  alu_index,
  input  word_t    alu_pc,
  input  word_t    alu_data,
  input  logic     alu_illegal,
  input  logic     alu_branch,
  input  logic     alu_prediction,
  input  logic     alu_taken,
  input  word_t    alu_target,
  // Multiplier writeback.
  input  logic     mul_valid,
  input  cb_idx_t  mul_index,
  input  word_t    mul_data,
  // Retirement and fetch redirect.
  output logic     retire_valid,
  output reg_idx_t retire_rd,
  output word_t    retire_data,
  output logic     retire_wen,
  output logic     redirect_valid,
  output word_t    redirect_pc,
  // Trap to the privilege unit.
  output logic     trap_req,
  output word_t    trap_epc,
  output cause_t   trap_cause,
  output word_t    trap_value,
  input  logic     trap_ack,
  // Fetch prediction.
  input  word_t    pred_pc,
  output logic     pred_taken
);

  // Commit stage to completion buffer.
  logic    wb_a_valid;
  cb_idx_t wb_a_index;
  word_t   wb_a_data;
  logic    wb_a_exception;
  cause_t  wb_a_cause;
  logic    wb_a_nowrite;
  logic    wb_a_redirect;
  logic    wb_m_valid;
  cb_idx_t wb_m_index;
  word_t   wb_m_data;

  // Commit stage to history table.
  logic    upd_valid;
  word_t   upd_pc;
  logic    upd_taken;

  // Buffer head and control.
  logic    head_ready;
  logic    head_exception;
  cause_t  head_cause;
  word_t   head_pc;
  word_t   head_value;
  logic    retire_en;
  logic    flush;

  // Port names line up across the blocks.
  ooo_commit_stage u_commit_stage (.*);

  completion_buffer u_completion_buffer (.*);

  commit_control u_commit_control (.*);

  branch_history_table u_branch_history_table (.*);

endmodule

`default_nettype wire

/* tests/tb_ooo_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_commit import ooo_commit_pkg::*;;

  logic     CLK;
  logic     nRST;
  logic     alloc_valid, alloc_ready;
  word_t    alloc_pc;
  reg_idx_t alloc_rd;
  cb_idx_t  alloc_index;
  logic     alu_valid, alu_illegal, alu_branch, alu_prediction, alu_taken;
  cb_idx_t  alu_index;
  word_t    alu_pc, alu_data, alu_target;
  logic     mul_valid;
  cb_idx_t  mul_index;
  word_t    mul_data;
  logic     retire_valid, retire_wen, redirect_valid;
  reg_idx_t retire_rd;
  word_t    retire_data, redirect_pc;
  logic     trap_req, trap_ack;
  word_t    trap_epc, trap_value;
  cause_t   trap_cause;
  word_t    pred_pc;
  logic     pred_taken;

  logic [15:0] lfsr = 16'd1533;
  reg_idx_t    pend_rd [$];  // Allocated rd values in program order.

  ooo_commit_top dut (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(logic [31:0] got, logic [31:0] exp, string what);
    assert (got === exp) else
      fail_stop($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic next_cycle();
    @(negedge CLK);
  endtask

  task automatic alloc(word_t pc, reg_idx_t rd, output cb_idx_t idx);
    int n;
    n = 0;
    alloc_valid = 1'b1;
    alloc_pc    = pc;
    alloc_rd    = rd;
    #1;
    while (!alloc_ready) begin
      next_cycle();
      #1;
      n++;
      if (n > 50) fail_stop("timeout: alloc_ready never went high");
    end
    idx = alloc_index;
    pend_rd.push_back(rd);
    next_cycle();
    alloc_valid = 1'b0;
  endtask

  task automatic wb_alu(cb_idx_t idx, word_t pc, word_t data, logic illegal, logic branch,
                        logic pred, logic taken, word_t target);
    alu_valid      = 1'b1;
    alu_index      = idx;
    alu_pc         = pc;
    alu_data       = data;
    alu_illegal    = illegal;
    alu_branch     = branch;
    alu_prediction = pred;
    alu_taken      = taken;
    alu_target     = target;
    next_cycle();
    alu_valid = 1'b0;
  endtask

  task automatic wb_mul(cb_idx_t idx, word_t data);
    mul_valid = 1'b1;
    mul_index = idx;
    mul_data  = data;
    next_cycle();
    mul_valid = 1'b0;
  endtask

  task automatic expect_retire(word_t data, logic wen, logic redir, word_t rpc);
    int       n;
    reg_idx_t rd;
    n = 0;
    #1;
    while (!retire_valid) begin
      next_cycle();
      #1;
      n++;
      if (n > 50) fail_stop("timeout: no retirement from the buffer head");
    end
    rd = pend_rd.pop_front();
    check_eq(32'(retire_rd), 32'(rd), "retire_rd");
    check_eq(32'(retire_wen), 32'(wen), "retire_wen");
    check_eq(32'(redirect_valid), 32'(redir), "redirect_valid");
    if (wen) check_eq(retire_data, data, "retire_data");
    if (redir) check_eq(redirect_pc, rpc, "redirect_pc");
    next_cycle();
  endtask

  task automatic wait_trap(word_t epc, cause_t cause, word_t value);
    int n;
    int hold;
    n = 0;
    #1;
    while (!trap_req) begin
      check_eq(32'(retire_valid), 32'd0, "retire_valid before trap");
      next_cycle();
      #1;
      n++;
      if (n > 50) fail_stop("timeout: trap_req never went high");
    end
    check_eq(trap_epc, epc, "trap_epc");
    check_eq(32'(trap_cause), 32'(cause), "trap_cause");
    check_eq(trap_value, value, "trap_value");
    hold = int'(lfsr_bits(3)) + 1;  // Privilege unit latency.
    repeat (hold) begin
      next_cycle();
      #1;
      check_eq(32'(trap_req), 32'd1, "trap_req held");
      check_eq(32'(retire_valid), 32'd0, "retire_valid during trap");
      check_eq(trap_epc, epc, "trap_epc held");
    end
    next_cycle();
    trap_ack = 1'b1;
    n = 0;
    #1;
    while (trap_req) begin
      next_cycle();
      #1;
      n++;
      if (n > 50) fail_stop("timeout: trap_req never dropped");
    end
    next_cycle();
    trap_ack = 1'b0;
    next_cycle();
    next_cycle();
    pend_rd.delete();
  endtask

  task automatic test_out_of_order();
    cb_idx_t idx [5];
    word_t   d [5];
    for (int i = 0; i < 5; i++) begin
      alloc(32'h1000 + 32'(4 * i), 5'(i + 1), idx[i]);
      d[i] = lfsr_bits(32);
    end
    mul_valid = 1'b1;  // Same cycle as the ALU write below.
    mul_index = idx[4];
    mul_data  = d[4];
    wb_alu(idx[2], 32'h1008, d[2], 1'b0, 1'b0, 1'b0, 1'b0, '0);
    mul_valid = 1'b0;
    wb_alu(idx[3], 32'h100C, d[3], 1'b0, 1'b0, 1'b0, 1'b0, '0);
    wb_mul(idx[1], d[1]);
    wb_alu(idx[0], 32'h1000, d[0], 1'b0, 1'b0, 1'b0, 1'b0, '0);
    for (int i = 0; i < 5; i++) expect_retire(d[i], 1'b1, 1'b0, '0);
  endtask

  task automatic test_full();
    cb_idx_t idx [8];
    for (int i = 0; i < 8; i++) alloc(32'h2000 + 32'(4 * i), 5'(i + 8), idx[i]);
    for (int i = 1; i < 8; i++) check_eq(32'(idx[i]), 32'(3'(idx[0] + 3'(i))), "alloc_index");
    #1;
    check_eq(32'(alloc_ready), 32'd0, "alloc_ready when full");
    next_cycle();
    wb_mul(idx[0], 32'h0);
    expect_retire(32'h0, 1'b1, 1'b0, '0);
    #1;
    check_eq(32'(alloc_ready), 32'd1, "alloc_ready after retire");
    next_cycle();
    for (int i = 1; i < 8; i++) begin
      wb_mul(idx[i], 32'(i * 3));
      expect_retire(32'(i * 3), 1'b1, 1'b0, '0);
    end
  endtask

  task automatic test_branch_ok();
    cb_idx_t b, x, y;
    alloc(32'h0084, 5'd0, b);
    alloc(32'h0088, 5'd20, x);
    alloc(32'h008C, 5'd21, y);
    wb_mul(y, 32'hCAFE);
    wb_alu(x, 32'h0088, 32'hBEEF, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    wb_alu(b, 32'h0084, 32'h0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0400);
    expect_retire('0, 1'b0, 1'b0, '0);
    expect_retire(32'hBEEF, 1'b1, 1'b0, '0);
    expect_retire(32'hCAFE, 1'b1, 1'b0, '0);
  endtask

  task automatic test_mispredict();
    cb_idx_t b, x, y;
    alloc(32'h0108, 5'd0, b);
    alloc(32'h010C, 5'd22, x);
    alloc(32'h0110, 5'd23, y);
    wb_mul(x, 32'h11);
    wb_mul(y, 32'h22);
    wb_alu(b, 32'h0108, 32'h0, 1'b0, 1'b1, 1'b0, 1'b1, 32'h0200);
    expect_retire('0, 1'b0, 1'b1, 32'h0200);
    pend_rd.delete();
    repeat (4) begin
      #1;
      check_eq(32'(retire_valid), 32'd0, "retire_valid after redirect");
      next_cycle();
    end
    check_eq(32'(alloc_index), 32'(3'(b + 3'd1)), "alloc_index after redirect");
    // Train the counter at pc 0x10C (slot 3).
    pred_pc = 32'h010C;
    repeat (2) wb_alu(3'd0, 32'h010C, '0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0300);
    #1;
    check_eq(32'(pred_taken), 32'd1, "pred_taken after two taken");
    next_cycle();
    wb_alu(3'd0, 32'h010C, '0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0300);
    #1;
    check_eq(32'(pred_taken), 32'd1, "pred_taken after one not-taken");
    next_cycle();
    wb_alu(3'd0, 32'h010C, '0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0300);
    #1;
    check_eq(32'(pred_taken), 32'd0, "pred_taken after two not-taken");
    next_cycle();
  endtask

  task automatic test_trap();
    cb_idx_t t, y;
    alloc(32'h0200, 5'd0, t);
    alloc(32'h0204, 5'd24, y);
    wb_mul(y, 32'h33);
    wb_alu(t, 32'h0200, '0, 1'b0, 1'b1, 1'b1, 1'b1, 32'h0302);
    wait_trap(32'h0200, CAUSE_MAL_INSN, 32'h0302);
    #1;
    check_eq(32'(alloc_ready), 32'd1, "alloc_ready after trap");
    check_eq(32'(alloc_index), 32'(t), "alloc_index after trap");
    next_cycle();
    alloc(32'h0300, 5'd25, t);
    wb_alu(t, 32'h0300, 32'h55, 1'b1, 1'b0, 1'b0, 1'b0, '0);
    wait_trap(32'h0300, CAUSE_ILLEGAL_INSN, 32'h0);
    #1;
    check_eq(32'(alloc_ready), 32'd1, "alloc_ready after illegal trap");
    check_eq(32'(alloc_index), 32'(t), "alloc_index after illegal trap");
  endtask

  initial begin
    nRST = 1'b0;
    alloc_valid = 1'b0;
    alloc_pc = '0;
    alloc_rd = '0;
    alu_valid = 1'b0;
    alu_index = '0;
    alu_pc = '0;
    alu_data = '0;
    alu_illegal = 1'b0;
    alu_branch = 1'b0;
    alu_prediction = 1'b0;
    alu_taken = 1'b0;
    alu_target = '0;
    mul_valid = 1'b0;
    mul_index = '0;
    mul_data = '0;
    trap_ack = 1'b0;
    pred_pc = '0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    next_cycle();
    test_out_of_order();
    test_full();
    test_branch_ok();
    test_mispredict();
    test_trap();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/ooo_commit_pkg.sv
logic/ooo_commit_stage.sv
logic/completion_buffer.sv
logic/commit_control.sv
logic/branch_history_table.sv
logic/ooo_commit_top.sv
tests/tb_ooo_commit.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, then check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_ooo_commit -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
